// File: logic/rv_exec_cfg.svh
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// Operand and result width
`define RV_XLEN 32

// Issue tag width
`define RV_TAG_W 4

// Result FIFO entries, equal to the upstream credits at reset
`define RV_QUEUE_DEPTH 4

// Saturation point of the downstream credit counter
`define RV_OUT_CREDITS 8

`endif

// File: logic/rv_exec_pkg.sv
`include "rv_exec_cfg.svh"

package rv_exec_pkg;

  // RV32I major opcodes handled by the execute subsystem
  typedef enum logic [6:0] {
    OPC_OTHER  = 7'b0000000,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [1:0] {
    RES_ALU     = 2'd0,
    RES_BRANCH  = 2'd1,
    RES_ILLEGAL = 2'd2
  } result_kind_e;

  typedef struct packed {
    logic [`RV_XLEN-1:0]  instr;
    logic [`RV_XLEN-1:0]  rs1_data;
    logic [`RV_XLEN-1:0]  rs2_data;
    logic [`RV_TAG_W-1:0] tag;
  } issue_req_t;

  // One-hot, at most one field set
  typedef struct packed {
    logic fn_add;
    logic fn_sub;
    logic fn_slt;
    logic fn_sltu;
    logic fn_xor;
    logic fn_or;
    logic fn_and;
    logic fn_sll;
    logic fn_srl;
    logic fn_sra;
  } alu_op_t;

  typedef struct packed {
    logic br_eq;
    logic br_ne;
    logic br_lt;
    logic br_ge;
    logic br_ltu;
    logic br_geu;
  } br_op_t;

  typedef struct packed {
    result_kind_e         kind;
    alu_op_t              alu_op;
    br_op_t               br_op;
    logic [`RV_XLEN-1:0]  op_1;
    logic [`RV_XLEN-1:0]  op_2;
    logic [`RV_TAG_W-1:0] tag;
  } exec_req_t;

  typedef struct packed {
    result_kind_e         kind;
    logic [`RV_XLEN-1:0]  value;
    logic                 taken;
    logic [`RV_TAG_W-1:0] tag;
  } exec_result_t;

endpackage

// File: logic/instr_decoder.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module instr_decoder import rv_exec_pkg::*; (
  input  logic       issue_valid,
  input  issue_req_t issue,
  output logic       req_valid,
  output exec_req_t  req
);

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] shamt;
  alu_op_t             alu_op;
  br_op_t              br_op;
  result_kind_e        kind;
  logic [`RV_XLEN-1:0] op_2;

  assign funct3 = issue.instr[14:12];
  assign funct7 = issue.instr[31:25];
  assign imm_i  = {{(`RV_XLEN-12){issue.instr[31]}}, issue.instr[31:20]};
  assign shamt  = {{(`RV_XLEN-5){1'b0}}, issue.instr[24:20]};

  always_comb begin
    case (issue.instr[6:0])
      OPC_OP:     opcode = OPC_OP;
      OPC_OP_IMM: opcode = OPC_OP_IMM;
      OPC_BRANCH: opcode = OPC_BRANCH;
      default:    opcode = OPC_OTHER;
    endcase
  end

  always_comb begin
    alu_op = '0;
    br_op  = '0;
    kind   = RES_ILLEGAL;
    op_2   = issue.rs2_data;
    case (opcode)
      OPC_OP: begin
        kind = RES_ALU;
        if (funct7 == F7_BASE) begin
          case (funct3)
            3'b000:  alu_op.fn_add  = 1'b1;
            3'b001:  alu_op.fn_sll  = 1'b1;
            3'b010:  alu_op.fn_slt  = 1'b1;
            3'b011:  alu_op.fn_sltu = 1'b1;
            3'b100:  alu_op.fn_xor  = 1'b1;
            3'b101:  alu_op.fn_srl  = 1'b1;
            3'b110:  alu_op.fn_or   = 1'b1;
            default: alu_op.fn_and  = 1'b1;
          endcase
        end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
          alu_op.fn_sub = 1'b1;
        end else if (funct7 == F7_ALT && funct3 == 3'b101) begin
          alu_op.fn_sra = 1'b1;
        end else begin
          kind = RES_ILLEGAL;
        end
      end
      OPC_OP_IMM: begin
        kind = RES_ALU;
        op_2 = imm_i;
        case (funct3)
          3'b000: alu_op.fn_add  = 1'b1;
          3'b010: alu_op.fn_slt  = 1'b1;
          3'b011: alu_op.fn_sltu = 1'b1;
          3'b100: alu_op.fn_xor  = 1'b1;
          3'b110: alu_op.fn_or   = 1'b1;
          3'b111: alu_op.fn_and  = 1'b1;
          3'b001: begin
            op_2 = shamt;
            if (funct7 == F7_BASE) alu_op.fn_sll = 1'b1;
            else kind = RES_ILLEGAL;
          end
          default: begin
            // Bit 30 picks SRAI over SRLI
            op_2 = shamt;
            if (funct7 == F7_BASE) alu_op.fn_srl = 1'b1;
            else if (funct7 == F7_ALT) alu_op.fn_sra = 1'b1;
            else kind = RES_ILLEGAL;
          end
        endcase
      end
      OPC_BRANCH: begin
        kind = RES_BRANCH;
        case (funct3)
          3'b000:  br_op.br_eq  = 1'b1;
          3'b001:  br_op.br_ne  = 1'b1;
          3'b100:  br_op.br_lt  = 1'b1;
          3'b101:  br_op.br_ge  = 1'b1;
          3'b110:  br_op.br_ltu = 1'b1;
          3'b111:  br_op.br_geu = 1'b1;
          default: kind = RES_ILLEGAL;
        endcase
      end
      default: kind = RES_ILLEGAL;
    endcase
    // Illegal encodings carry no operation
    if (kind == RES_ILLEGAL) begin
      alu_op = '0;
      br_op  = '0;
    end
  end

  assign req_valid  = issue_valid;
  assign req.kind   = kind;
  assign req.alu_op = alu_op;
  assign req.br_op  = br_op;
  assign req.op_1   = issue.rs1_data;
  assign req.op_2   = op_2;
  assign req.tag    = issue.tag;

endmodule

// File: logic/int_alu.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module int_alu import rv_exec_pkg::*; (
  input  logic                clock,
  input  logic                rst_n,
  input  alu_op_t             alu_op,
  input  logic [`RV_XLEN-1:0] op_1,
  input  logic [`RV_XLEN-1:0] op_2,
  output logic [`RV_XLEN-1:0] alu_out
);

  logic signed [`RV_XLEN-1:0] s_op_1;
  logic signed [`RV_XLEN-1:0] s_op_2;
  logic [`RV_XLEN-1:0]        arith_out;
  logic [`RV_XLEN-1:0]        logic_out;
  logic [`RV_XLEN-1:0]        shift_out;
  logic [`RV_XLEN-1:0]        next_out;
  logic                       is_arith;
  logic                       is_logic;
  logic                       is_shift;

  assign s_op_1 = op_1;
  assign s_op_2 = op_2;

  // Arithmetic group, compares yield 0 or 1
  assign arith_out = ({`RV_XLEN{alu_op.fn_add}}  & (op_1 + op_2)) |
                     ({`RV_XLEN{alu_op.fn_sub}}  & (op_1 - op_2)) |
                     ({`RV_XLEN{alu_op.fn_slt}}  & `RV_XLEN'(s_op_1 < s_op_2)) |
                     ({`RV_XLEN{alu_op.fn_sltu}} & `RV_XLEN'(op_1 < op_2));
  assign is_arith  = alu_op.fn_add | alu_op.fn_sub | alu_op.fn_slt | alu_op.fn_sltu;

  assign logic_out = ({`RV_XLEN{alu_op.fn_xor}} & (op_1 ^ op_2)) |
                     ({`RV_XLEN{alu_op.fn_or}}  & (op_1 | op_2)) |
                     ({`RV_XLEN{alu_op.fn_and}} & (op_1 & op_2));
  assign is_logic  = alu_op.fn_xor | alu_op.fn_or | alu_op.fn_and;

  // Only the low five bits of the amount count
  assign shift_out = ({`RV_XLEN{alu_op.fn_sll}} & (op_1 << op_2[4:0])) |
                     ({`RV_XLEN{alu_op.fn_srl}} & (op_1 >> op_2[4:0])) |
                     ({`RV_XLEN{alu_op.fn_sra}} & $unsigned(s_op_1 >>> op_2[4:0]));
  assign is_shift  = alu_op.fn_sll | alu_op.fn_srl | alu_op.fn_sra;

  assign next_out = is_arith ? arith_out :
                    is_logic ? logic_out :
                    is_shift ? shift_out :
                    '0;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      alu_out <= '0;
    end else begin
      alu_out <= next_out;
    end
  end

endmodule

// File: logic/branch_compare.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module branch_compare import rv_exec_pkg::*; (
  input  logic                clock,
  input  logic                rst_n,
  input  br_op_t              br_op,
  input  logic [`RV_XLEN-1:0] op_1,
  input  logic [`RV_XLEN-1:0] op_2,
  output logic                br_out
);

  logic signed [`RV_XLEN-1:0] s_op_1;
  logic signed [`RV_XLEN-1:0] s_op_2;
  logic                       lt;
  logic                       ltu;
  logic                       next_out;

  assign s_op_1 = op_1;
  assign s_op_2 = op_2;
  assign lt     = s_op_1 < s_op_2;
  assign ltu    = op_1 < op_2;

  // ge and geu are the complements of lt and ltu
  assign next_out = (br_op.br_eq  & (op_1 == op_2)) |
                    (br_op.br_ne  & (op_1 != op_2)) |
                    (br_op.br_lt  & lt)  |
                    (br_op.br_ge  & !lt) |
                    (br_op.br_ltu & ltu) |
                    (br_op.br_geu & !ltu);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      br_out <= 1'b0;
    end else begin
      br_out <= next_out;
    end
  end

endmodule

// File: logic/result_queue.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module result_queue import rv_exec_pkg::*; (
  input  logic         clock,
  input  logic         rst_n,
  input  logic         in_valid,
  input  exec_result_t in_result,
  input  logic         out_credit,
  output logic         result_valid,
  output exec_result_t result,
  output logic         issue_credit
);

  localparam int PTR_W = $clog2(`RV_QUEUE_DEPTH);
  localparam int CRD_W = $clog2(`RV_OUT_CREDITS + 1);

  exec_result_t     mem [`RV_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic [CRD_W-1:0] credits;
  logic             pop;

  // Upstream credits keep the FIFO from overflowing
  assign pop = (count != '0) && (credits != '0);

  always_ff @(posedge clock) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_result;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({in_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Downstream credit count, saturating
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      credits <= '0;
    end else begin
      case ({out_credit, pop})
        2'b10: begin
          if (credits != CRD_W'(`RV_OUT_CREDITS)) begin
            credits <= credits + 1'b1;
          end
        end
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      issue_credit <= 1'b0;
    end else begin
      result_valid <= pop;
      issue_credit <= pop;
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      result <= mem[rd_ptr];
    end
  end

endmodule

// File: logic/exec_unit_top.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module exec_unit_top import rv_exec_pkg::*; (
  input  logic         clock,
  input  logic         rst_n,
  input  logic         issue_valid,
  input  issue_req_t   issue,
  output logic         issue_credit,
  input  logic         out_credit,
  output logic         result_valid,
  output exec_result_t result
);

  logic                 req_valid;
  exec_req_t            req;
  logic [`RV_XLEN-1:0]  alu_out;
  logic                 br_out;
  logic                 ex_valid;
  result_kind_e         ex_kind;
  logic [`RV_TAG_W-1:0] ex_tag;
  exec_result_t         ex_result;

  instr_decoder u_decoder (
    .issue_valid (issue_valid),
    .issue       (issue),
    .req_valid   (req_valid),
    .req         (req)
  );

  int_alu u_alu (
    .clock   (clock),
    .rst_n   (rst_n),
    .alu_op  (req.alu_op),
    .op_1    (req.op_1),
    .op_2    (req.op_2),
    .alu_out (alu_out)
  );

  branch_compare u_branch (
    .clock  (clock),
    .rst_n  (rst_n),
    .br_op  (req.br_op),
    .op_1   (req.op_1),
    .op_2   (req.op_2),
    .br_out (br_out)
  );

  // Runs alongside the ALU and comparator registers
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= req_valid;
    end
  end

  always_ff @(posedge clock) begin
    ex_kind <= req.kind;
    ex_tag  <= req.tag;
  end

  assign ex_result.kind  = ex_kind;
  assign ex_result.value = (ex_kind == RES_ALU) ? alu_out : '0;
  assign ex_result.taken = (ex_kind == RES_BRANCH) ? br_out : 1'b0;
  assign ex_result.tag   = ex_tag;

  result_queue u_queue (
    .clock        (clock),
    .rst_n        (rst_n),
    .in_valid     (ex_valid),
    .in_result    (ex_result),
    .out_credit   (out_credit),
    .result_valid (result_valid),
    .result       (result),
    .issue_credit (issue_credit)
  );

endmodule

// File: bench/exec_unit_assertions.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module exec_unit_assertions import rv_exec_pkg::*; (
  input logic         clock,
  input logic         rst_n,
  input logic         issue_valid,
  input issue_req_t   issue,
  input logic         issue_credit,
  input logic         out_credit,
  input logic         result_valid,
  input exec_result_t result
);

  exec_result_t expected [16];
  exec_result_t exp_head;
  logic [3:0]   wr_idx;
  logic [3:0]   rd_idx;
  int           out_held;
  int           up_held;
  int unsigned  fail_count = 0;

  // Expected result straight from the RV32I encoding rules
  function automatic exec_result_t model(input issue_req_t r);
    exec_result_t e;
    logic [2:0]   f3;
    logic [6:0]   f7;
    logic [31:0]  a;
    logic [31:0]  b;
    logic         alt;
    f3 = r.instr[14:12];
    f7 = r.instr[31:25];
    a = r.rs1_data;
    b = r.rs2_data;
    alt = 1'b0;
    e = '0;
    e.kind = RES_ILLEGAL;
    e.tag = r.tag;
    case (r.instr[6:0])
      7'b0110011: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) e.kind = RES_ALU;
        alt = f7[5];
      end
      7'b0010011: begin
        b = {{20{r.instr[31]}}, r.instr[31:20]};
        if (f3 == 3'd1 || f3 == 3'd5) b = {27'd0, r.instr[24:20]};
        if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)) begin
          e.kind = RES_ALU;
        end
        alt = (f3 == 3'd5) && f7[5];
      end
      7'b1100011: begin
        if (f3 != 3'd2 && f3 != 3'd3) e.kind = RES_BRANCH;
        case (f3)
          3'd0:    e.taken = (a == b);
          3'd1:    e.taken = (a != b);
          3'd4:    e.taken = ($signed(a) < $signed(b));
          3'd5:    e.taken = ($signed(a) >= $signed(b));
          3'd6:    e.taken = (a < b);
          3'd7:    e.taken = (a >= b);
          default: e.taken = 1'b0;
        endcase
      end
      default: ;
    endcase
    if (e.kind == RES_ALU) begin
      case (f3)
        3'd0: e.value = alt ? a - b : a + b;
        3'd1: e.value = a << b[4:0];
        3'd2: e.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: e.value = (a < b) ? 32'd1 : 32'd0;
        3'd4: e.value = a ^ b;
        3'd5: begin
          if (alt) e.value = $signed(a) >>> b[4:0];
          else e.value = a >> b[4:0];
        end
        3'd6: e.value = a | b;
        default: e.value = a & b;
      endcase
    end
    return e;
  endfunction

  assign exp_head = expected[rd_idx];

  always_ff @(posedge clock) begin
    if (issue_valid) expected[wr_idx] <= model(issue);
  end

  // Shadow counts of the expectation queue and both credit balances
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      wr_idx <= '0;
      rd_idx <= '0;
      out_held <= 0;
      up_held <= `RV_QUEUE_DEPTH;
    end else begin
      wr_idx <= wr_idx + 4'(issue_valid);
      rd_idx <= rd_idx + 4'(result_valid);
      out_held <= out_held + int'(out_credit) - int'(result_valid);
      up_held <= up_held - int'(issue_valid) + int'(issue_credit);
    end
  end

  result_order_a: assert property (@(posedge clock) disable iff (!rst_n)
    result_valid |-> (wr_idx != rd_idx && result == exp_head))
    else begin
      $error("Mismatch at %0t: result %h, expected %h", $time, result, exp_head);
      fail_count++;
    end

  out_credit_a: assert property (@(posedge clock) disable iff (!rst_n)
    result_valid |-> out_held > 0)
    else begin
      $error("result sent without a downstream credit");
      fail_count++;
    end

  up_balance_a: assert property (@(posedge clock) disable iff (!rst_n)
    up_held >= 0 && up_held <= `RV_QUEUE_DEPTH)
    else begin
      $error("upstream credit balance %0d out of range", up_held);
      fail_count++;
    end

  credit_pair_a: assert property (@(posedge clock) disable iff (!rst_n)
    issue_credit == result_valid)
    else begin
      $error("issue_credit and result_valid are not paired");
      fail_count++;
    end

endmodule

bind exec_unit_top exec_unit_assertions chk_i (.*);

// File: bench/exec_unit_tb.sv
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module exec_unit_tb import rv_exec_pkg::*; ();

  localparam int TOTAL_ISSUES    = 128;
  localparam int WATCHDOG_CYCLES = TOTAL_ISSUES * 20 + 200;

  logic         clock;
  logic         rst_n;
  logic         issue_valid;
  issue_req_t   issue;
  logic         issue_credit;
  logic         out_credit;
  logic         result_valid;
  exec_result_t result;

  logic [31:0]          lcg_state = 32'hcbdc_a84a;
  logic [`RV_TAG_W-1:0] next_tag = '0;
  logic [`RV_TAG_W-1:0] tag_q [$];
  int up_credits = `RV_QUEUE_DEPTH;
  int out_held = 0;
  int issued = 0;
  int results_seen = 0;
  int credit_returns = 0;
  int tb_errors = 0;
  int tests_done = 0;
  bit grant_on = 1'b0;
  bit grant_pending = 1'b0;

  exec_unit_top dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3);
    return {imm, 5'd1, f3, 5'd3, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3);
    return {7'd0, 5'd2, 5'd1, f3, 5'd0, 7'b1100011};
  endfunction

  // One clock: collect credits and results, then drive the next inputs
  task automatic next_cycle();
    logic [`RV_TAG_W-1:0] want;
    @(posedge clock);
    if (issue_credit) begin
      up_credits++;
      credit_returns++;
    end
    if (up_credits > `RV_QUEUE_DEPTH) begin
      $display("Issue credit returned at %0t with no issue outstanding", $time);
      tb_errors++;
      up_credits = `RV_QUEUE_DEPTH;
    end
    if (result_valid) begin
      results_seen++;
      out_held--;
      if (tag_q.size() == 0) begin
        $display("A result arrived at %0t with no issue outstanding", $time);
        tb_errors++;
      end else begin
        want = tag_q.pop_front();
        if (result.tag != want) begin
          $display("Mismatch at %0t: tag %0d received, tag %0d next in issue order",
                   $time, result.tag, want);
          tb_errors++;
        end
      end
    end
    issue_valid <= 1'b0;
    out_credit <= 1'b0;
    if (grant_pending || (grant_on && out_held < `RV_OUT_CREDITS)) begin
      out_credit <= 1'b1;
      out_held++;
      grant_pending = 1'b0;
    end
  endtask

  task automatic issue_instr(input logic [31:0] instr, input logic [31:0] rs1,
                             input logic [31:0] rs2);
    next_cycle();
    while (up_credits == 0) next_cycle();
    issue_valid <= 1'b1;
    issue <= '{instr: instr, rs1_data: rs1, rs2_data: rs2, tag: next_tag};
    tag_q.push_back(next_tag);
    next_tag++;
    up_credits--;
    issued++;
  endtask

  task automatic drain();
    while (results_seen < issued) next_cycle();
    repeat (2) next_cycle();
  endtask

  task automatic end_test(input string name);
    tests_done++;
    $display("test %0d (%s) finished: %0d testbench errors, %0d assertion failures so far",
             tests_done, name, tb_errors, dut_i.chk_i.fail_count);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] w;
    logic [2:0]  f3;
    int          k;
    int          base;
    rst_n = 1'b0;
    issue_valid = 1'b0;
    issue = '0;
    out_credit = 1'b0;
    repeat (4) @(posedge clock);
    rst_n <= 1'b1;

    // Nothing may leave before the first downstream credit
    repeat (8) next_cycle();
    issue_instr(enc_r(7'h00, 3'd0), 32'd5, 32'd7);
    issue_instr(enc_i(12'h7ff, 3'd0), 32'd1, 32'd0);
    repeat (10) next_cycle();
    if (results_seen != 0 || credit_returns != 0) begin
      $display("Outputs moved before any downstream credit was granted");
      tb_errors++;
    end
    grant_on = 1'b1;
    drain();
    end_test("reset and idle");

    for (int i = 0; i < 40; i++) begin
      k = rand_word() % 7;
      f3 = (k < 2) ? 3'd0 : (k < 5) ? 3'(k) : 3'(k + 1);
      a = rand_word();
      b = (i % 8 == 0) ? a : rand_word();
      if (i % 2 == 0) issue_instr(enc_r((k == 1) ? 7'h20 : 7'h00, f3), a, b);
      else issue_instr(enc_i(b[11:0], f3), a, rand_word());
    end
    drain();
    end_test("random alu");

    for (int i = 0; i < 24; i++) begin
      k = i % 3;
      f3 = (k == 0) ? 3'd1 : 3'd5;
      a = rand_word();
      if (i % 2 == 0) a[31] = 1'b1;
      b = rand_word();
      if (i < 12) issue_instr(enc_r((k == 2) ? 7'h20 : 7'h00, f3), a, b);
      else issue_instr(enc_i({(k == 2) ? 7'h20 : 7'h00, b[4:0]}, f3), a, b);
    end
    drain();
    end_test("shifts");

    for (int i = 0; i < 36; i++) begin
      case (i % 6)
        0: begin
          a = rand_word();
          b = a;
        end
        1: begin
          a = 32'd7;
          b = 32'd3;
        end
        2: begin
          a = 32'd3;
          b = 32'd7;
        end
        3: begin
          a = 32'hffff_fff0;
          b = 32'd5;
        end
        4: begin
          a = 32'd5;
          b = 32'hffff_fff0;
        end
        default: begin
          a = 32'h8000_0000;
          b = 32'h7fff_ffff;
        end
      endcase
      k = i / 6;
      f3 = (k < 2) ? 3'(k) : 3'(k + 2);
      issue_instr(enc_b(f3), a, b);
    end
    drain();
    end_test("branches");

    for (int i = 0; i < 10; i++) begin
      case (i)
        0: w = 32'h0000_2083;
        1: w = 32'h0020_a023;
        2: w = 32'h1234_51b7;
        3: w = 32'h0000_006f;
        4: w = enc_r(7'h01, 3'd0);
        5: w = enc_r(7'h20, 3'd4);
        6: w = enc_i(12'h405, 3'd1);
        7: w = enc_i(12'h025, 3'd5);
        8: w = enc_b(3'd2);
        default: w = enc_b(3'd3);
      endcase
      issue_instr(w, rand_word(), rand_word());
    end
    drain();
    end_test("illegal encodings");

    // Use up the leftover downstream credits first
    grant_on = 1'b0;
    while (out_held > 0) begin
      issue_instr(enc_r(7'h00, 3'd6), rand_word(), rand_word());
      drain();
    end
    base = results_seen;
    for (int i = 0; i < 4; i++) issue_instr(enc_r(7'h00, 3'd4), rand_word(), rand_word());
    repeat (12) next_cycle();
    if (up_credits != 0 || results_seen != base) begin
      $display("Upstream did not stall after four issues without downstream credit");
      tb_errors++;
    end
    for (int i = 0; i < 8; i++) begin
      grant_pending = 1'b1;
      while (results_seen < base + i + 1) next_cycle();
      if (i < 4) issue_instr(enc_i(12'hf80, 3'd7), rand_word(), 32'd0);
    end
    drain();
    if (credit_returns != results_seen) begin
      $display("Issue credits returned (%0d) do not match results sent (%0d)",
               credit_returns, results_seen);
      tb_errors++;
    end
    end_test("back-pressure");

    $display("summary: %0d tests, %0d issues, %0d results, %0d errors, %0d assertion failures",
             tests_done, issued, results_seen, tb_errors, dut_i.chk_i.fail_count);
    if (tb_errors == 0 && dut_i.chk_i.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog expired: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: build.f
+incdir+logic
logic/rv_exec_pkg.sv
logic/instr_decoder.sv
logic/int_alu.sv
logic/branch_compare.sv
logic/result_queue.sv
logic/exec_unit_top.sv
bench/exec_unit_assertions.sv
bench/exec_unit_tb.sv

// File: Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_exec_pkg.sv
      - logic/instr_decoder.sv
      - logic/int_alu.sv
      - logic/branch_compare.sv
      - logic/result_queue.sv
      - logic/exec_unit_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/exec_unit_assertions.sv
      - bench/exec_unit_tb.sv
